// File: sources.f
+incdir+hw
hw/malu_pkg.sv
hw/dp_bram.sv
hw/malu_ctrl.sv
hw/malu_addr_gen.sv
hw/malu_lane_ops.sv
hw/malu_bank_route.sv
hw/malu_top.sv
test/malu_tb.sv

// File: run.sh
#!/bin/sh
# build and run with Verilator, the log decides pass or fail
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --timescale 1ns/100ps --top-module malu_tb \
    -f sources.f -o malu_sim > build.log 2>&1 \
    && ./obj_dir/malu_sim > sim.log 2>&1 \
    || { cat build.log; echo "build or simulation failed"; exit 1; }
cat sim.log
grep -q "Done: errors found" sim.log && exit 1 || exit 0

// File: test/malu_tb.sv
`timescale 1ns/100ps
`include "malu_settings.svh"

module malu_tb;
    import malu_pkg::*;

    // words moved through the host ports or produced, per test
    localparam int word_total  = 32 + 48 + 16 + 8 + 96;
    localparam int cycle_limit = word_total * 4 + 200;

    logic    clk;
    logic    arst_n;
    logic    i_en;
    cmd_t    i_command;
    size_u   i_m1_size;
    size_u   i_m2_size;
    addr_t   i_m1_address;
    addr_t   i_m2_address;
    addr_t   i_dest_address;
    addr_t   i_host0_addr;
    logic    i_host0_ce;
    logic    i_host0_we;
    word_u   i_host0_d;
    addr_t   i_host1_addr;
    logic    i_host1_ce;
    logic    i_host1_we;
    word_u   i_host1_d;
    status_t o_status;
    word_u   o_host0_q;
    word_u   o_host1_q;

    word_u       model0 [65536];
    word_u       model1 [65536];
    logic [31:0] lcg_state;
    logic        active_bank;
    int          errors;
    int          test_errors;
    int          checks;
    int          tests_run;
    int          cycle_cnt;

    malu_top dut (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic size_u make_size(input addr_t rows, input addr_t lanes);
        size_u s;
        s.dim.length = rows;
        s.dim.width  = lanes;
        return s;
    endfunction

    function automatic word_u model_read(input logic bank, input addr_t addr);
        return bank ? model1[addr] : model0[addr];
    endfunction

    task automatic model_write(input logic bank, input addr_t addr, input word_u data);
        if (bank) begin
            model1[addr] = data;
        end else begin
            model0[addr] = data;
        end
    endtask

    task automatic compare_word(input word_u got, input word_u exp, input string name);
        checks++;
        if (got.raw !== exp.raw) begin
            $display("Mismatch at %0t: %s got %h expected %h", $time, name, got.raw, exp.raw);
            errors++;
            test_errors++;
        end
    endtask

    task automatic compare_status(input status_t got, input status_t exp, input string name);
        checks++;
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
            errors++;
            test_errors++;
        end
    endtask

    task automatic finish_test(input string name);
        $display("test %s finished with %0d errors", name, test_errors);
        tests_run++;
        test_errors = 0;
    endtask

    // one host write, the model follows
    task automatic host_write(input logic bank, input addr_t addr, input word_u data);
        if (bank) begin
            i_host1_addr = addr;
            i_host1_d    = data;
            i_host1_ce   = 1'b1;
            i_host1_we   = 1'b1;
        end else begin
            i_host0_addr = addr;
            i_host0_d    = data;
            i_host0_ce   = 1'b1;
            i_host0_we   = 1'b1;
        end
        model_write(bank, addr, data);
        @(negedge clk);
        i_host0_ce = 1'b0;
        i_host0_we = 1'b0;
        i_host1_ce = 1'b0;
        i_host1_we = 1'b0;
    endtask

    // read one word, data is back after one edge
    task automatic host_check(input logic bank, input addr_t addr);
        word_u got;
        if (bank) begin
            i_host1_addr = addr;
            i_host1_ce   = 1'b1;
        end else begin
            i_host0_addr = addr;
            i_host0_ce   = 1'b1;
        end
        @(negedge clk);
        got = bank ? o_host1_q : o_host0_q;
        compare_word(got, model_read(bank, addr), $sformatf("o_host%0d_q[%h]", bank, addr));
        i_host0_ce = 1'b0;
        i_host1_ce = 1'b0;
    endtask

    task automatic fill_random(input logic bank, input addr_t base, input int n);
        word_u w;
        for (int i = 0; i < n; i++) begin
            w.raw = next_rand();
            host_write(bank, base + addr_t'(i), w);
        end
    endtask

    task automatic check_range(input logic bank, input addr_t base, input int n);
        for (int i = 0; i < n; i++) begin
            host_check(bank, base + addr_t'(i));
        end
    endtask

    task automatic expect_relu(input logic bank, input addr_t src, input addr_t dst, input int n);
        word_u s;
        word_u e;
        for (int i = 0; i < n; i++) begin
            s = model_read(bank, src + addr_t'(i));
            // a set sign bit means a negative lane
            e.raw[31:16] = s.raw[31] ? 16'h0000 : s.raw[31:16];
            e.raw[15:0]  = s.raw[15] ? 16'h0000 : s.raw[15:0];
            model_write(bank, dst + addr_t'(i), e);
        end
    endtask

    task automatic expect_add(input logic bank, input addr_t m1, input addr_t m2,
                              input addr_t dst, input int n);
        word_u a;
        word_u b;
        word_u e;
        for (int i = 0; i < n; i++) begin
            a = model_read(bank, m1 + addr_t'(i));
            b = model_read(bank, m2 + addr_t'(i));
            e.raw[31:16] = a.raw[31:16] + b.raw[31:16];
            e.raw[15:0]  = a.raw[15:0] + b.raw[15:0];
            model_write(bank, dst + addr_t'(i), e);
        end
    endtask

    // start one command, follow the status until idle again
    task automatic run_op(input cmd_t cmd, input size_u size, input addr_t m1, input addr_t m2,
                          input addr_t dest, input logic check_mask);
        word_u zero_w;
        int    busy_seen;
        zero_w         = '0;
        busy_seen      = 0;
        i_command      = cmd;
        i_m1_size      = size;
        i_m2_size      = size;
        i_m1_address   = m1;
        i_m2_address   = m2;
        i_dest_address = dest;
        i_en           = 1'b1;
        if (check_mask) begin
            // host reads pending the whole time, they must stay hidden
            i_host0_addr = m1;
            i_host0_ce   = 1'b1;
            i_host1_addr = m1;
            i_host1_ce   = 1'b1;
        end
        @(negedge clk);
        i_en = 1'b0;
        @(negedge clk);
        while (o_status == ST_BUSY) begin
            busy_seen++;
            if (check_mask) begin
                compare_word(o_host0_q, zero_w, "o_host0_q");
                compare_word(o_host1_q, zero_w, "o_host1_q");
            end
            @(negedge clk);
        end
        compare_status(o_status, ST_DONE, "o_status");
        i_host0_ce = 1'b0;
        i_host1_ce = 1'b0;
        @(negedge clk);
        compare_status(o_status, ST_IDLE, "o_status");
        if (check_mask && busy_seen == 0) begin
            $display("status never showed busy during the operation at %0t", $time);
            errors++;
            test_errors++;
        end
    endtask

    task automatic test_reset_host();
        compare_status(o_status, ST_IDLE, "o_status");
        fill_random(1'b0, 16'h0100, 8);
        fill_random(1'b1, 16'h0100, 8);
        check_range(1'b0, 16'h0100, 8);
        check_range(1'b1, 16'h0100, 8);
        finish_test("reset_host");
    endtask

    task automatic test_relu();
        fill_random(active_bank, 16'h0200, 12);
        run_op(`MALU_CMD_RELU, make_size(16'd3, 16'd8), 16'h0200, 16'h0000, 16'h0400, 1'b0);
        expect_relu(active_bank, 16'h0200, 16'h0400, 12);
        check_range(active_bank, 16'h0400, 12);
        check_range(active_bank, 16'h0200, 12);
        finish_test("relu");
    endtask

    task automatic test_add();
        fill_random(active_bank, 16'h0600, 4);
        fill_random(active_bank, 16'h0700, 4);
        run_op(`MALU_CMD_MADD, make_size(16'd2, 16'd4), 16'h0600, 16'h0700, 16'h0800, 1'b0);
        expect_add(active_bank, 16'h0600, 16'h0700, 16'h0800, 4);
        check_range(active_bank, 16'h0800, 4);
        finish_test("add");
    endtask

    task automatic test_status_mask();
        run_op(`MALU_CMD_RELU, make_size(16'd1, 16'd8), 16'h0200, 16'h0000, 16'h0a00, 1'b1);
        expect_relu(active_bank, 16'h0200, 16'h0a00, 4);
        check_range(active_bank, 16'h0a00, 4);
        finish_test("status_mask");
    endtask

    task automatic test_load_swap();
        // known bank 0 words where the bank 1 results land
        fill_random(1'b0, 16'h0c00, 12);
        run_op(`MALU_CMD_LOAD, make_size(16'd0, 16'd0), 16'h0000, 16'h0000, 16'h0000, 1'b0);
        active_bank = ~active_bank;
        fill_random(1'b1, 16'h0200, 12);
        run_op(`MALU_CMD_RELU, make_size(16'd3, 16'd8), 16'h0200, 16'h0000, 16'h0c00, 1'b0);
        expect_relu(active_bank, 16'h0200, 16'h0c00, 12);
        check_range(1'b1, 16'h0c00, 12);
        check_range(1'b1, 16'h0200, 12);
        check_range(1'b0, 16'h0200, 12);
        check_range(1'b0, 16'h0400, 12);
        check_range(1'b0, 16'h0c00, 12);
        finish_test("load_swap");
    endtask

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < cycle_limit) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout: the run did not finish within %0d cycles", cycle_limit);
        $display("Done: errors found");
        $finish;
    end

    initial begin
        arst_n         = 1'b0;
        i_en           = 1'b0;
        i_command      = `MALU_CMD_IDLE;
        i_m1_size      = '0;
        i_m2_size      = '0;
        i_m1_address   = '0;
        i_m2_address   = '0;
        i_dest_address = '0;
        i_host0_addr   = '0;
        i_host0_ce     = 1'b0;
        i_host0_we     = 1'b0;
        i_host0_d      = '0;
        i_host1_addr   = '0;
        i_host1_ce     = 1'b0;
        i_host1_we     = 1'b0;
        i_host1_d      = '0;
        lcg_state      = 32'hef2e5028;
        active_bank    = 1'b0;
        errors         = 0;
        test_errors    = 0;
        checks         = 0;
        tests_run      = 0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        test_reset_host();
        test_relu();
        test_add();
        test_status_mask();
        test_load_swap();
        $display("tests: %0d, checks: %0d, errors: %0d", tests_run, checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// File: hw/malu_top.sv
`timescale 1ns/100ps
`include "malu_settings.svh"

module malu_top (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              i_en,
    input  malu_pkg::cmd_t    i_command,
    input  malu_pkg::size_u   i_m1_size,
    input  malu_pkg::size_u   i_m2_size,
    input  malu_pkg::addr_t   i_m1_address,
    input  malu_pkg::addr_t   i_m2_address,
    input  malu_pkg::addr_t   i_dest_address,
    input  malu_pkg::addr_t   i_host0_addr,
    input  logic              i_host0_ce,
    input  logic              i_host0_we,
    input  malu_pkg::word_u   i_host0_d,
    input  malu_pkg::addr_t   i_host1_addr,
    input  logic              i_host1_ce,
    input  logic              i_host1_we,
    input  malu_pkg::word_u   i_host1_d,
    output malu_pkg::status_t o_status,
    output malu_pkg::word_u   o_host0_q,
    output malu_pkg::word_u   o_host1_q
);
    import malu_pkg::*;

    // add expects i_m2_size to equal i_m1_size, only m1 sets the count
    logic  busy, bank_sel, rd_ce, res_valid, host_lock;
    cmd_t  run_cmd;
    addr_t rd_addr, wr_addr;
    word_u res, core_q;
    addr_t b0_addr0, b0_addr1, b1_addr0, b1_addr1;
    logic  b0_ce0, b0_ce1, b0_we1, b1_ce0, b1_ce1, b1_we1;
    word_u b0_d1, b0_q0, b0_q1, b1_d1, b1_q0, b1_q1;

    assign host_lock = busy | i_en;

    malu_ctrl u_ctrl (
        .clk(clk), .arst_n(arst_n), .i_en(i_en), .i_command(i_command),
        .i_m1_size(i_m1_size), .i_res_valid(res_valid), .o_status(o_status),
        .o_cmd(run_cmd), .o_busy(busy), .o_width(), .o_bank_sel(bank_sel)
    );

    malu_addr_gen u_addr_gen (
        .clk(clk), .arst_n(arst_n), .i_en(i_en), .i_busy(busy), .i_cmd(run_cmd),
        .i_res_valid(res_valid), .i_m1_address(i_m1_address),
        .i_m2_address(i_m2_address), .i_dest_address(i_dest_address),
        .o_rd_addr(rd_addr), .o_rd_ce(rd_ce), .o_wr_addr(wr_addr)
    );

    malu_lane_ops u_lane_ops (
        .clk(clk), .arst_n(arst_n), .i_busy(busy), .i_cmd(run_cmd),
        .i_rd_valid(rd_ce), .i_rd_data(core_q), .o_res(res), .o_res_valid(res_valid)
    );

    malu_bank_route u_route (
        .i_busy_or_start(host_lock), .i_bank_sel(bank_sel),
        .i_rd_addr(rd_addr), .i_rd_ce(rd_ce), .i_wr_addr(wr_addr),
        .i_wr_en(res_valid), .i_wr_data(res),
        .i_host0_addr(i_host0_addr), .i_host0_ce(i_host0_ce),
        .i_host0_we(i_host0_we), .i_host0_d(i_host0_d),
        .i_host1_addr(i_host1_addr), .i_host1_ce(i_host1_ce),
        .i_host1_we(i_host1_we), .i_host1_d(i_host1_d),
        .i_bank0_q0(b0_q0), .i_bank0_q1(b0_q1), .i_bank1_q0(b1_q0), .i_bank1_q1(b1_q1),
        .o_bank0_addr0(b0_addr0), .o_bank0_ce0(b0_ce0), .o_bank0_addr1(b0_addr1),
        .o_bank0_ce1(b0_ce1), .o_bank0_we1(b0_we1), .o_bank0_d1(b0_d1),
        .o_bank1_addr0(b1_addr0), .o_bank1_ce0(b1_ce0), .o_bank1_addr1(b1_addr1),
        .o_bank1_ce1(b1_ce1), .o_bank1_we1(b1_we1), .o_bank1_d1(b1_d1),
        .o_core_q(core_q), .o_host0_q(o_host0_q), .o_host1_q(o_host1_q)
    );

    // port 0 only ever reads
    dp_bram #(.depth(`MALU_BANK_DEPTH)) bank0 (
        .clk(clk), .i_addr0(b0_addr0), .i_ce0(b0_ce0), .i_we0(1'b0), .i_d0('0),
        .i_addr1(b0_addr1), .i_ce1(b0_ce1), .i_we1(b0_we1), .i_d1(b0_d1),
        .o_q0(b0_q0), .o_q1(b0_q1)
    );

    dp_bram #(.depth(`MALU_BANK_DEPTH)) bank1 (
        .clk(clk), .i_addr0(b1_addr0), .i_ce0(b1_ce0), .i_we0(1'b0), .i_d0('0),
        .i_addr1(b1_addr1), .i_ce1(b1_ce1), .i_we1(b1_we1), .i_d1(b1_d1),
        .o_q0(b1_q0), .o_q1(b1_q1)
    );

endmodule

// File: hw/malu_bank_route.sv
`timescale 1ns/100ps

module malu_bank_route (
    input  logic            i_busy_or_start,
    input  logic            i_bank_sel,
    input  malu_pkg::addr_t i_rd_addr,
    input  logic            i_rd_ce,
    input  malu_pkg::addr_t i_wr_addr,
    input  logic            i_wr_en,
    input  malu_pkg::word_u i_wr_data,
    input  malu_pkg::addr_t i_host0_addr,
    input  logic            i_host0_ce,
    input  logic            i_host0_we,
    input  malu_pkg::word_u i_host0_d,
    input  malu_pkg::addr_t i_host1_addr,
    input  logic            i_host1_ce,
    input  logic            i_host1_we,
    input  malu_pkg::word_u i_host1_d,
    input  malu_pkg::word_u i_bank0_q0,
    input  malu_pkg::word_u i_bank0_q1,
    input  malu_pkg::word_u i_bank1_q0,
    input  malu_pkg::word_u i_bank1_q1,
    output malu_pkg::addr_t o_bank0_addr0,
    output logic            o_bank0_ce0,
    output malu_pkg::addr_t o_bank0_addr1,
    output logic            o_bank0_ce1,
    output logic            o_bank0_we1,
    output malu_pkg::word_u o_bank0_d1,
    output malu_pkg::addr_t o_bank1_addr0,
    output logic            o_bank1_ce0,
    output malu_pkg::addr_t o_bank1_addr1,
    output logic            o_bank1_ce1,
    output logic            o_bank1_we1,
    output malu_pkg::word_u o_bank1_d1,
    output malu_pkg::word_u o_core_q,
    output malu_pkg::word_u o_host0_q,
    output malu_pkg::word_u o_host1_q
);

    // core reads on port 0 of the active bank, the other bank stays quiet
    assign o_bank0_addr0 = i_bank_sel ? '0 : i_rd_addr;
    assign o_bank0_ce0   = i_rd_ce && !i_bank_sel;
    assign o_bank1_addr0 = i_bank_sel ? i_rd_addr : '0;
    assign o_bank1_ce0   = i_rd_ce && i_bank_sel;
    assign o_core_q      = i_bank_sel ? i_bank1_q0 : i_bank0_q0;

    // port 1 is the core write port while running, otherwise the host port
    always_comb begin
        if (i_busy_or_start) begin
            o_bank0_addr1 = i_wr_addr;
            o_bank0_ce1   = i_wr_en && !i_bank_sel;
            o_bank0_we1   = i_wr_en && !i_bank_sel;
            o_bank0_d1    = i_wr_data;
            o_bank1_addr1 = i_wr_addr;
            o_bank1_ce1   = i_wr_en && i_bank_sel;
            o_bank1_we1   = i_wr_en && i_bank_sel;
            o_bank1_d1    = i_wr_data;
        end else begin
            o_bank0_addr1 = i_host0_addr;
            o_bank0_ce1   = i_host0_ce;
            o_bank0_we1   = i_host0_we;
            o_bank0_d1    = i_host0_d;
            o_bank1_addr1 = i_host1_addr;
            o_bank1_ce1   = i_host1_ce;
            o_bank1_we1   = i_host1_we;
            o_bank1_d1    = i_host1_d;
        end
    end

    // host sees zero while the core owns the banks
    assign o_host0_q = i_busy_or_start ? '0 : i_bank0_q1;
    assign o_host1_q = i_busy_or_start ? '0 : i_bank1_q1;

endmodule

// File: hw/malu_lane_ops.sv
`timescale 1ns/100ps
`include "malu_settings.svh"

module malu_lane_ops (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            i_busy,
    input  malu_pkg::cmd_t  i_cmd,
    input  logic            i_rd_valid,
    input  malu_pkg::word_u i_rd_data,
    output malu_pkg::word_u o_res,
    output logic            o_res_valid
);
    import malu_pkg::*;

    logic  data_valid;
    logic  pair_half;
    logic  res_valid_q;
    logic  is_add;
    logic  is_relu;
    logic  take;
    word_u first_q;
    word_u res_nxt;
    word_u res_q;

    function automatic lane_t relu_lane(lane_t x);
        return (x < 0) ? lane_t'(0) : x;
    endfunction

    assign is_add  = (i_cmd == `MALU_CMD_MADD);
    assign is_relu = (i_cmd == `MALU_CMD_RELU);

    // add needs the m2 word of a pair before it has a result
    assign take = i_busy && data_valid && (is_relu || (is_add && pair_half));

    always_comb begin
        res_nxt = i_rd_data;
        if (is_add) begin
            res_nxt.lanes.hi = first_q.lanes.hi + i_rd_data.lanes.hi;
            res_nxt.lanes.lo = first_q.lanes.lo + i_rd_data.lanes.lo;
        end else begin
            res_nxt.lanes.hi = relu_lane(i_rd_data.lanes.hi);
            res_nxt.lanes.lo = relu_lane(i_rd_data.lanes.lo);
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            data_valid  <= 1'b0;
            pair_half   <= 1'b0;
            res_valid_q <= 1'b0;
        end else begin
            data_valid  <= i_rd_valid;
            res_valid_q <= take;
            if (!i_busy) begin
                pair_half <= 1'b0;
            end else if (data_valid && is_add) begin
                pair_half <= ~pair_half;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (data_valid && is_add && !pair_half) begin
            first_q <= i_rd_data;
        end
        if (take) begin
            res_q <= res_nxt;
        end
    end

    assign o_res = res_q;
    // results still in flight once the count is met are dropped
    assign o_res_valid = res_valid_q && i_busy;

endmodule

// File: hw/malu_addr_gen.sv
`timescale 1ns/100ps
`include "malu_settings.svh"

module malu_addr_gen (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            i_en,
    input  logic            i_busy,
    input  malu_pkg::cmd_t  i_cmd,
    input  logic            i_res_valid,
    input  malu_pkg::addr_t i_m1_address,
    input  malu_pkg::addr_t i_m2_address,
    input  malu_pkg::addr_t i_dest_address,
    output malu_pkg::addr_t o_rd_addr,
    output logic            o_rd_ce,
    output malu_pkg::addr_t o_wr_addr
);
    import malu_pkg::*;

    addr_t m1_ptr;
    addr_t m2_ptr;
    addr_t dest_ptr;
    logic  op_sel;
    logic  is_add;
    logic  start;

    assign is_add = (i_cmd == `MALU_CMD_MADD);
    assign start  = !i_busy && i_en;

    // one read per busy cycle, add takes m1 and m2 in turn
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            m1_ptr <= '0;
            m2_ptr <= '0;
            op_sel <= 1'b0;
        end else if (start) begin
            m1_ptr <= i_m1_address;
            m2_ptr <= i_m2_address;
            op_sel <= 1'b0;
        end else if (i_busy) begin
            if (is_add && op_sel) begin
                m2_ptr <= m2_ptr + addr_t'(1);
            end else begin
                m1_ptr <= m1_ptr + addr_t'(1);
            end
            op_sel <= is_add && !op_sel;
        end
    end

    // destination steps once per written result
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            dest_ptr <= '0;
        end else if (start) begin
            dest_ptr <= i_dest_address;
        end else if (i_res_valid) begin
            dest_ptr <= dest_ptr + addr_t'(1);
        end
    end

    assign o_rd_addr = (is_add && op_sel) ? m2_ptr : m1_ptr;
    assign o_rd_ce   = i_busy;
    assign o_wr_addr = dest_ptr;

endmodule

// File: hw/malu_ctrl.sv
`timescale 1ns/100ps
`include "malu_settings.svh"

module malu_ctrl (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              i_en,
    input  malu_pkg::cmd_t    i_command,
    input  malu_pkg::size_u   i_m1_size,
    input  logic              i_res_valid,
    output malu_pkg::status_t o_status,
    output malu_pkg::cmd_t    o_cmd,
    output logic              o_busy,
    output malu_pkg::addr_t   o_width,
    output logic              o_bank_sel
);
    import malu_pkg::*;

    status_t state;
    status_t state_nxt;
    cmd_t    cmd_q;
    size_u   size_q;
    addr_t   col_cnt;
    addr_t   row_cnt;
    addr_t   words_per_row;
    logic    start;
    logic    has_datapath;
    logic    row_end;
    logic    finish;
    logic    load_flag;
    logic    bank_sel_q;

    assign start = (state == ST_IDLE) && i_en;

    // two lanes per word
    assign words_per_row = size_q.dim.width >> 1;
    assign row_end = (col_cnt == words_per_row);
    assign has_datapath = (cmd_q == `MALU_CMD_RELU) || (cmd_q == `MALU_CMD_MADD);

    // load and unknown codes produce no results and end at once
    assign finish = !has_datapath ||
                    (i_res_valid && row_end && (row_cnt == size_q.dim.length));

    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE: if (i_en) state_nxt = ST_BUSY;
            ST_BUSY: if (finish) state_nxt = ST_DONE;
            ST_DONE: state_nxt = ST_IDLE;
            default: state_nxt = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= ST_IDLE;
            cmd_q     <= `MALU_CMD_IDLE;
            load_flag <= 1'b0;
        end else begin
            state <= state_nxt;
            if (start) begin
                cmd_q     <= i_command;
                load_flag <= (i_command == `MALU_CMD_LOAD);
            end else if (state == ST_DONE) begin
                load_flag <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            size_q <= i_m1_size;
        end
    end

    // result position inside the matrix, both counters start at one
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            col_cnt <= addr_t'(1);
            row_cnt <= addr_t'(1);
        end else if (state == ST_DONE) begin
            col_cnt <= addr_t'(1);
            row_cnt <= addr_t'(1);
        end else if ((state == ST_BUSY) && i_res_valid) begin
            if (row_end) begin
                col_cnt <= addr_t'(1);
                row_cnt <= row_cnt + addr_t'(1);
            end else begin
                col_cnt <= col_cnt + addr_t'(1);
            end
        end
    end

    // swap banks as a load leaves done
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            bank_sel_q <= 1'b0;
        end else if ((state == ST_DONE) && load_flag) begin
            bank_sel_q <= ~bank_sel_q;
        end
    end

    assign o_status   = state;
    assign o_busy     = (state == ST_BUSY);
    assign o_cmd      = cmd_q;
    assign o_width    = size_q.dim.width;
    assign o_bank_sel = bank_sel_q;

endmodule

// File: hw/dp_bram.sv
`timescale 1ns/100ps
`include "malu_settings.svh"

module dp_bram #(
    parameter int depth = `MALU_BANK_DEPTH
) (
    input  logic                    clk,
    input  logic [`MALU_ADDR_W-1:0] i_addr0,
    input  logic                    i_ce0,
    input  logic                    i_we0,
    input  logic [`MALU_WORD_W-1:0] i_d0,
    input  logic [`MALU_ADDR_W-1:0] i_addr1,
    input  logic                    i_ce1,
    input  logic                    i_we1,
    input  logic [`MALU_WORD_W-1:0] i_d1,
    output logic [`MALU_WORD_W-1:0] o_q0,
    output logic [`MALU_WORD_W-1:0] o_q1
);

    logic [`MALU_WORD_W-1:0] mem [depth];

    // both ports read the old contents on a write
    always_ff @(posedge clk) begin
        if (i_ce0) begin
            if (i_we0) begin
                mem[i_addr0] <= i_d0;
            end
            o_q0 <= mem[i_addr0];
        end
        if (i_ce1) begin
            if (i_we1) begin
                mem[i_addr1] <= i_d1;
            end
            o_q1 <= mem[i_addr1];
        end
    end

endmodule

// File: hw/malu_pkg.sv
`include "malu_settings.svh"

package malu_pkg;

    typedef logic signed [`MALU_LANE_W-1:0] lane_t;
    typedef logic [`MALU_ADDR_W-1:0] addr_t;
    typedef logic [2:0] cmd_t;

    // RAM word, raw or as two lanes
    typedef union packed {
        logic [`MALU_WORD_W-1:0] raw;
        struct packed {
            lane_t hi;
            lane_t lo;
        } lanes;
    } word_u;

    // matrix shape, rows in the upper half and lanes per row in the lower
    typedef union packed {
        logic [2*`MALU_ADDR_W-1:0] raw;
        struct packed {
            addr_t length;
            addr_t width;
        } dim;
    } size_u;

    // one-hot {done, busy, idle}
    typedef enum logic [2:0] {
        ST_IDLE = 3'b001,
        ST_BUSY = 3'b010,
        ST_DONE = 3'b100
    } status_t;

endpackage

// File: hw/malu_settings.svh
`ifndef MALU_SETTINGS_SVH
`define MALU_SETTINGS_SVH

// one lane is Q5.11 fixed point, a RAM word carries two lanes
`define MALU_LANE_W      16
`define MALU_WORD_W      32
`define MALU_ADDR_W      16
`define MALU_BANK_DEPTH  65536

// command codes
`define MALU_CMD_IDLE    3'd0
`define MALU_CMD_MADD    3'd2
`define MALU_CMD_RELU    3'd4
`define MALU_CMD_LOAD    3'd5

`endif
